// ==== list.f ====
src/xu_pkg.sv
src/arith_unit.sv
src/logic_unit.sv
src/shift_unit.sv
src/branch_unit.sv
src/mem_unit.sv
src/execute.sv
verif/execute_assert.sv
verif/tb_execute.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
rm -f sim.log
{ verilator --binary --timing --assert -f list.f --top-module tb_execute -o tb_execute \
    && ./obj_dir/tb_execute; } > sim.log 2>&1 \
    || echo "STATUS: FAIL" >> sim.log
cat sim.log
! grep -q "STATUS: FAIL" sim.log

// ==== src/arith_unit.sv ====
/*
 * Arithmetic unit
 *   add and sub on one adder and one subtractor
 *   slt and sltu from the subtraction flags
 */

`timescale 1ns/1ns

module arith_unit import xu_pkg::*; (
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  instr_e          op_i,
    output logic [XLEN-1:0] result_o
);

    logic [XLEN-1:0] sum;
    logic [XLEN:0]   diff;                              // Top bit is the borrow
    logic            ovf;                               // Signed overflow of a - b
    logic            lt_s;
    logic            lt_u;

    assign sum  = a_i + b_i;
    assign diff = {1'b0, a_i} - {1'b0, b_i};            // Shared by sub and compares

    // Overflow when signs differ and result sign differs from a
    assign ovf  = (a_i[XLEN-1] ^ b_i[XLEN-1]) & (a_i[XLEN-1] ^ diff[XLEN-1]);
    assign lt_s = diff[XLEN-1] ^ ovf;                   // Sign corrected by overflow
    assign lt_u = diff[XLEN];                           // Borrow out

    always_comb begin
        case (op_i)
            OP_ADD:  result_o = sum;
            OP_SUB:  result_o = diff[XLEN-1:0];
            OP_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
            default: result_o = '0;                     // Masked or foreign op
        endcase
    end

endmodule

// ==== src/branch_unit.sv ====
/*
 * Branch unit
 *   one compare set shared by the six conditions
 *   branch, jal and jalr targets
 *   link address and its write enable
 */

`timescale 1ns/1ns

module branch_unit import xu_pkg::*; (
    input  logic [XLEN-1:0] a_i,                        // rs1 compare operand, jalr base
    input  logic [XLEN-1:0] b_i,                        // rs2 compare operand
    input  logic [XLEN-1:0] offset_i,                   // Immediate offset
    input  logic [XLEN-1:0] pc_i,
    input  instr_e          op_i,
    output logic [XLEN-1:0] link_o,
    output logic [XLEN-1:0] target_o,
    output logic            jump_o,
    output logic            link_we_o
);

    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] pc_rel;                            // pc + offset
    logic [XLEN-1:0] reg_rel;                           // op_a + offset

    ////////////////////
    // Compares
    ////////////////////
    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    ////////////////////
    // Addresses
    ////////////////////
    assign pc_rel   = pc_i + offset_i;
    assign reg_rel  = a_i + offset_i;
    assign link_o   = pc_i + INSTR_BYTES;               // Return address
    assign target_o = (op_i == OP_JALR) ? {reg_rel[XLEN-1:1], 1'b0}     // Bit 0 cleared
                                        : pc_rel;

    always_comb begin
        case (op_i)
            OP_BEQ:           jump_o = eq;
            OP_BNE:           jump_o = ~eq;
            OP_BLT:           jump_o = lt_s;
            OP_BGE:           jump_o = ~lt_s;
            OP_BLTU:          jump_o = lt_u;
            OP_BGEU:          jump_o = ~lt_u;
            OP_JAL, OP_JALR:  jump_o = 1'b1;            // Always taken
            default:          jump_o = 1'b0;
        endcase
    end

    // Only jumps write the link back
    assign link_we_o = (op_i == OP_JAL) || (op_i == OP_JALR);

endmodule

// ==== src/execute.sv ====
/*
 * Execute stage top level
 *   dispatcher masking the operation per unit
 *   arithmetic, logic, shift, branch and memory units
 *   operand B bypass
 *   registered retire collector
 */

`timescale 1ns/1ns

module execute import xu_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,
    input  issue_t  issue_i,                            // New instruction every cycle
    output retire_t retire_o,                           // One cycle after issue
    output mem_rd_t rd_req_o                            // Same cycle as issue
);

    instr_e            arith_op;
    instr_e            logic_op;
    instr_e            shift_op;
    instr_e            branch_op;
    instr_e            mem_op;

    logic [XLEN-1:0]   arith_res;
    logic [XLEN-1:0]   logic_res;
    logic [XLEN-1:0]   shift_res;
    logic [XLEN-1:0]   bypass_res;
    logic [XLEN-1:0]   br_link;
    logic [XLEN-1:0]   br_target;
    logic              br_jump;
    logic              br_we;
    logic [XLEN-1:0]   mem_addr;
    logic [STRB_W-1:0] mem_strobe;
    logic [XLEN-1:0]   mem_wdata;
    logic              mem_we;

    ////////////////////
    // Dispatcher
    ////////////////////
    assign arith_op  = (issue_i.xu == XU_ARITH)  ? issue_i.op : NOTOKEN;
    assign logic_op  = (issue_i.xu == XU_LOGIC)  ? issue_i.op : NOTOKEN;
    assign shift_op  = (issue_i.xu == XU_SHIFT)  ? issue_i.op : NOTOKEN;
    assign branch_op = (issue_i.xu == XU_BRANCH) ? issue_i.op : NOTOKEN;
    assign mem_op    = (issue_i.xu == XU_MEMORY) ? issue_i.op : NOTOKEN;

    ////////////////////
    // Units
    ////////////////////
    arith_unit i_arith (
        .a_i(issue_i.op_a), .b_i(issue_i.op_b), .op_i(arith_op), .result_o(arith_res)
    );

    logic_unit i_logic (
        .a_i(issue_i.op_a), .b_i(issue_i.op_b), .op_i(logic_op), .result_o(logic_res)
    );

    shift_unit i_shift (
        .a_i(issue_i.op_a), .shamt_i(issue_i.op_b[SHAMT_W-1:0]),
        .op_i(shift_op), .result_o(shift_res)
    );

    branch_unit i_branch (
        .a_i(issue_i.op_a), .b_i(issue_i.op_b), .offset_i(issue_i.op_c),
        .pc_i(issue_i.pc), .op_i(branch_op),
        .link_o(br_link), .target_o(br_target), .jump_o(br_jump), .link_we_o(br_we)
    );

    mem_unit i_mem (
        .a_i(issue_i.op_a), .b_i(issue_i.op_b), .data_i(issue_i.op_c), .op_i(mem_op),
        .rd_req_o(rd_req_o), .addr_o(mem_addr), .strobe_o(mem_strobe),
        .wdata_o(mem_wdata), .rb_we_o(mem_we)
    );

    assign bypass_res = issue_i.op_b;                   // Move through unchanged

    ////////////////////
    // Collector
    ////////////////////
    always_ff @(posedge clk) begin
        retire_o.tag <= issue_i.tag;
        case (issue_i.xu)                               // Payload, no reset
            XU_ARITH:  begin retire_o.result0 <= arith_res;  end
            XU_LOGIC:  begin retire_o.result0 <= logic_res;  end
            XU_SHIFT:  begin retire_o.result0 <= shift_res;  end
            XU_BRANCH: begin retire_o.result0 <= br_link;    end
            XU_MEMORY: begin retire_o.result0 <= mem_wdata;  end
            default:   begin retire_o.result0 <= bypass_res; end
        endcase
        case (issue_i.xu)
            XU_BRANCH: retire_o.result1 <= br_target;
            XU_MEMORY: retire_o.result1 <= mem_addr;    // Store address
            default:   retire_o.result1 <= '0;
        endcase

        if (rst_i) begin                                // Clear control fields
            retire_o.jump       <= 1'b0;
            retire_o.we         <= 1'b0;
            retire_o.mem_access <= 1'b0;
            retire_o.write      <= '0;
            retire_o.op         <= NOTOKEN;
        end else begin
            retire_o.op <= issue_i.op;
            case (issue_i.xu)
                XU_BRANCH: begin
                    retire_o.jump       <= br_jump;
                    retire_o.we         <= br_we;       // Link only for jumps
                    retire_o.mem_access <= 1'b0;
                    retire_o.write      <= '0;
                end
                XU_MEMORY: begin
                    retire_o.jump       <= 1'b0;
                    retire_o.we         <= mem_we;      // Loads only
                    retire_o.mem_access <= 1'b1;
                    retire_o.write      <= mem_strobe;
                end
                default: begin                          // ALU units and bypass
                    retire_o.jump       <= 1'b0;
                    retire_o.we         <= 1'b1;
                    retire_o.mem_access <= 1'b0;
                    retire_o.write      <= '0;
                end
            endcase
        end
    end

endmodule

// ==== src/logic_unit.sv ====
/*
 * Logic unit
 *   bitwise and, or, xor
 *   zero for every other operation
 */

`timescale 1ns/1ns

module logic_unit import xu_pkg::*; (
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  instr_e          op_i,
    output logic [XLEN-1:0] result_o
);

    always_comb begin
        case (op_i)
            OP_AND:  result_o = a_i & b_i;
            OP_OR:   result_o = a_i | b_i;
            OP_XOR:  result_o = a_i ^ b_i;
            default: result_o = '0;                     // Unit idle when not selected
        endcase
    end

endmodule

// ==== src/mem_unit.sv ====
/*
 * Memory unit
 *   effective address generation
 *   load read request
 *   store byte strobes and lane-replicated write data
 */

`timescale 1ns/1ns

module mem_unit import xu_pkg::*; (
    input  logic [XLEN-1:0]   a_i,                      // Base register
    input  logic [XLEN-1:0]   b_i,                      // Offset
    input  logic [XLEN-1:0]   data_i,                   // Store data
    input  instr_e            op_i,
    output mem_rd_t           rd_req_o,
    output logic [XLEN-1:0]   addr_o,
    output logic [STRB_W-1:0] strobe_o,
    output logic [XLEN-1:0]   wdata_o,
    output logic              rb_we_o                   // Loads write the register bank
);

    logic [XLEN-1:0]   addr;
    logic              is_load;
    logic [STRB_W-1:0] lanes;                           // Strobes before alignment

    assign addr   = a_i + b_i;
    assign addr_o = addr;

    always_comb begin
        case (op_i)
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: is_load = 1'b1;
            default:                             is_load = 1'b0;
        endcase
    end

    ////////////////////
    // Read request
    ////////////////////
    assign rd_req_o.addr = addr;
    assign rd_req_o.en   = is_load;
    assign rb_we_o       = is_load;

    ////////////////////
    // Store path
    ////////////////////
    always_comb begin
        case (op_i)
            OP_SB: begin
                lanes   = 4'b0001;                      // One byte
                wdata_o = {STRB_W{data_i[7:0]}};
            end
            OP_SH: begin
                lanes   = 4'b0011;                      // Two bytes
                wdata_o = {(STRB_W/2){data_i[15:0]}};
            end
            OP_SW: begin
                lanes   = 4'b1111;                      // Full word
                wdata_o = data_i;
            end
            default: begin
                lanes   = '0;                           // Loads and idle slots
                wdata_o = '0;
            end
        endcase
    end

    // Strobes move to the addressed byte lane
    assign strobe_o = lanes << addr[1:0];

endmodule

// ==== src/shift_unit.sv ====
/*
 * Barrel shifter
 *   five-stage logarithmic right shifter
 *   left shift by bit reversal around the same stages
 *   arithmetic fill for sra
 */

`timescale 1ns/1ns

module shift_unit import xu_pkg::*; (
    input  logic [XLEN-1:0]    a_i,
    input  logic [SHAMT_W-1:0] shamt_i,                 // Low bits of operand B
    input  instr_e             op_i,
    output logic [XLEN-1:0]    result_o
);

    function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] v);
        logic [XLEN-1:0] r;
        for (int k = 0; k < XLEN; k++) begin
            r[k] = v[XLEN-1-k];
        end
        return r;
    endfunction

    logic                       left;                   // sll selected
    logic                       fill;                   // Bit shifted in from the top
    logic [SHAMT_W:0][XLEN-1:0] stage;                  // Stage inputs plus final

    assign left     = (op_i == OP_SLL);
    assign fill     = (op_i == OP_SRA) & a_i[XLEN-1];
    assign stage[0] = left ? bit_rev(a_i) : a_i;

    for (genvar i = 0; i < SHAMT_W; i++) begin : g_stage
        localparam int STEP = 1 << i;                   // 1, 2, 4, 8, 16
        assign stage[i+1] = shamt_i[i] ? {{STEP{fill}}, stage[i][XLEN-1:STEP]}
                                       : stage[i];
    end

    always_comb begin
        case (op_i)
            OP_SLL:          result_o = bit_rev(stage[SHAMT_W]);    // Undo reversal
            OP_SRL, OP_SRA:  result_o = stage[SHAMT_W];
            default:         result_o = '0;
        endcase
    end

endmodule

// ==== src/xu_pkg.sv ====
/*
 * Shared definitions for the execute stage
 *   data, tag, strobe and shift-amount widths
 *   operation and execution-unit selector enums
 *   issue word, retire word and memory read request
 */

package xu_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int XLEN    = 32;                        // Data path width
    localparam int TAG_W   = 4;                         // Instruction tag
    localparam int STRB_W  = 4;                         // Byte lanes per word
    localparam int SHAMT_W = 5;                         // Shift amount bits
    localparam int OP_W    = 5;                         // Operation code
    localparam int XU_W    = 3;                         // Unit selector

    localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4;    // Link step, one instruction

    ////////////////////
    // Operations
    ////////////////////
    typedef enum logic [OP_W-1:0] {
        NOTOKEN,                                        // Idle slot or masked unit
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU,                // Arithmetic unit
        OP_AND, OP_OR, OP_XOR,                          // Logic unit
        OP_SLL, OP_SRL, OP_SRA,                         // Shifter
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE,                 // Conditional branches
        OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR,                                // Unconditional jumps
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,            // Loads
        OP_SB, OP_SH, OP_SW                             // Stores
    } instr_e;

    typedef enum logic [XU_W-1:0] {
        XU_BYPASS,                                      // Operand B passes through
        XU_ARITH,
        XU_LOGIC,
        XU_SHIFT,
        XU_BRANCH,
        XU_MEMORY
    } xu_e;

    ////////////////////
    // Stage words
    ////////////////////
    typedef struct packed {
        logic [XLEN-1:0]  pc;                           // Address of the instruction
        logic [XLEN-1:0]  op_a;
        logic [XLEN-1:0]  op_b;
        logic [XLEN-1:0]  op_c;                         // Offset or store data
        instr_e           op;
        xu_e              xu;                           // Target unit
        logic [TAG_W-1:0] tag;
    } issue_t;

    typedef struct packed {
        logic [XLEN-1:0]   result0;                     // Main result or link
        logic [XLEN-1:0]   result1;                     // Target or store address
        logic              jump;                        // Taken branch or jump
        logic              we;                          // Register bank write enable
        logic              mem_access;                  // Memory unit instruction
        logic [STRB_W-1:0] write;                       // Store byte strobes
        instr_e            op;
        logic [TAG_W-1:0]  tag;
    } retire_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;                          // Effective load address
        logic            en;                            // Read strobe
    } mem_rd_t;

endpackage

// ==== verif/execute_assert.sv ====
/*
 * Bound checks on the execute stage
 *   cleared control fields after reset
 *   store strobes only with a memory access
 *   jump only after a branch-unit issue
 *   read request only for loads
 */

`timescale 1ns/1ns

module execute_assert import xu_pkg::*; (
    input logic    clk,
    input logic    rst_i,
    input issue_t  issue_i,
    input retire_t retire_o,
    input mem_rd_t rd_req_o
);

    logic issue_load;                                   // Load sent to the memory unit

    assign issue_load = (issue_i.xu == XU_MEMORY)
                        && (issue_i.op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW});

    a_reset_clear: assert property (@(posedge clk)
        rst_i |=> (!retire_o.jump && !retire_o.we && !retire_o.mem_access
                   && retire_o.write == '0 && retire_o.op == NOTOKEN))
        else $error("Control fields not cleared after reset");

    a_write_mem: assert property (@(posedge clk) disable iff (rst_i)
        retire_o.write != '0 |-> retire_o.mem_access)
        else $error("Store strobes without a memory access");

    // Jump retires one cycle after the branch issue
    a_jump_branch: assert property (@(posedge clk) disable iff (rst_i)
        retire_o.jump |-> $past(issue_i.xu) == XU_BRANCH)
        else $error("Jump retired without a branch-unit issue");

    a_rd_load: assert property (@(posedge clk) rd_req_o.en |-> issue_load)
        else $error("Read request raised for a non-load issue");

endmodule

bind execute execute_assert i_execute_assert (
    .clk(clk), .rst_i(rst_i), .issue_i(issue_i), .retire_o(retire_o), .rd_req_o(rd_req_o)
);

// ==== verif/tb_execute.sv ====
/*
 * Testbench for the execute stage
 *   clock, reset, directed and seeded random instruction stream
 *   reference model one cycle behind issue
 *   field checks as concurrent assertions on the falling edge
 */

`timescale 1ns/1ns

module tb_execute import xu_pkg::*; ();

    localparam int RST_CYC = 16;
    localparam int N_RAND  = 400;
    localparam int MAX_CYC = 3000;                      // Watchdog limit
    localparam logic [31:0] CORNER [6] = '{32'h0, 32'hFFFF_FFFF, 32'h7FFF_FFFF,
                                           32'h8000_0000, 32'h1, 32'h0000_001F};

    logic        clk;
    logic        rst_i;
    issue_t      issue_i;
    retire_t     retire_o;
    mem_rd_t     rd_req_o;
    retire_t     exp_q;                                 // Model word, one cycle behind
    logic        exp_rd_en;
    logic        chk_on;
    string       test_name;
    string       issue_name;                            // Name that travels with issue_i
    string       name_q;
    int          mismatches;
    int          timeouts;
    integer      seed;
    logic [31:0] pc_cnt;
    logic [3:0]  tag_cnt;

    execute i_execute (.clk(clk), .rst_i(rst_i), .issue_i(issue_i),
                       .retire_o(retire_o), .rd_req_o(rd_req_o));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                         // 40 ns period
    end

    function automatic logic is_load(instr_e op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    function automatic xu_e unit_of(instr_e op);
        if (op inside {OP_ADD, OP_SUB, OP_SLT, OP_SLTU}) return XU_ARITH;
        if (op inside {OP_AND, OP_OR, OP_XOR}) return XU_LOGIC;
        if (op inside {OP_SLL, OP_SRL, OP_SRA}) return XU_SHIFT;
        if (op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JAL, OP_JALR})
            return XU_BRANCH;
        if (op == NOTOKEN) return XU_BYPASS;
        return XU_MEMORY;
    endfunction

    function automatic logic [31:0] pick_operand();
        if ($random(seed) % 2 == 0) return CORNER[$unsigned($random(seed)) % 6];
        return $random(seed);
    endfunction

    ////////////////////
    // Reference model
    ////////////////////
    function automatic retire_t expect_retire(issue_t w, logic rst);
        retire_t     r;
        logic [31:0] addr;
        logic [3:0]  size_mask;
        r    = '0;
        r.tag = w.tag;
        r.op  = w.op;
        addr  = w.op_a + w.op_b;
        case (w.xu)
            XU_ARITH, XU_LOGIC, XU_SHIFT: begin
                r.we = 1'b1;
                case (w.op)                             // Foreign ops give zero
                    OP_ADD:  r.result0 = w.op_a + w.op_b;
                    OP_SUB:  r.result0 = w.op_a - w.op_b;
                    OP_SLT:  r.result0 = {31'b0, $signed(w.op_a) < $signed(w.op_b)};
                    OP_SLTU: r.result0 = {31'b0, w.op_a < w.op_b};
                    OP_AND:  r.result0 = w.op_a & w.op_b;
                    OP_OR:   r.result0 = w.op_a | w.op_b;
                    OP_XOR:  r.result0 = w.op_a ^ w.op_b;
                    OP_SLL:  r.result0 = w.op_a << w.op_b[4:0];
                    OP_SRL:  r.result0 = w.op_a >> w.op_b[4:0];
                    OP_SRA:  r.result0 = $unsigned($signed(w.op_a) >>> w.op_b[4:0]);
                    default: r.result0 = '0;
                endcase
                if (unit_of(w.op) != w.xu) r.result0 = '0;
            end
            XU_BRANCH: begin
                r.result0 = w.pc + 32'd4;               // Link
                r.result1 = (w.op == OP_JALR) ? ((w.op_a + w.op_c) & ~32'd1) : w.pc + w.op_c;
                r.we      = (w.op == OP_JAL) || (w.op == OP_JALR);
                case (w.op)
                    OP_BEQ:  r.jump = (w.op_a == w.op_b);
                    OP_BNE:  r.jump = (w.op_a != w.op_b);
                    OP_BLT:  r.jump = $signed(w.op_a) < $signed(w.op_b);
                    OP_BGE:  r.jump = $signed(w.op_a) >= $signed(w.op_b);
                    OP_BLTU: r.jump = w.op_a < w.op_b;
                    OP_BGEU: r.jump = w.op_a >= w.op_b;
                    default: r.jump = r.we;             // Jumps always taken
                endcase
            end
            XU_MEMORY: begin
                r.result1    = addr;
                r.mem_access = 1'b1;
                r.we         = is_load(w.op);
                case (w.op)
                    OP_SB:   r.result0 = {4{w.op_c[7:0]}};
                    OP_SH:   r.result0 = {2{w.op_c[15:0]}};
                    OP_SW:   r.result0 = w.op_c;
                    default: r.result0 = '0;
                endcase
                size_mask = (w.op == OP_SB) ? 4'b0001 :
                            (w.op == OP_SH) ? 4'b0011 :
                            (w.op == OP_SW) ? 4'b1111 : 4'b0000;
                r.write   = size_mask << addr[1:0]; // Lanes past 3 drop out
            end
            default: begin
                r.result0 = w.op_b;                     // Bypass
                r.we      = 1'b1;
            end
        endcase
        if (rst) begin
            r.jump       = 1'b0;
            r.we         = 1'b0;
            r.mem_access = 1'b0;
            r.write      = '0;
            r.op         = NOTOKEN;
        end
        return r;
    endfunction

    always @(posedge clk) begin
        exp_q  <= expect_retire(issue_i, rst_i);
        name_q <= issue_name;
        chk_on <= 1'b1;
    end

    assign exp_rd_en = (issue_i.xu == XU_MEMORY) && is_load(issue_i.op);

    task automatic report_mismatch(string field, logic [31:0] exp_v, logic [31:0] act_v);
        mismatches++;
        $display("Mismatch test=%s field=%s expected=%h actual=%h", name_q, field, exp_v, act_v);
    endtask

    ////////////////////
    // Checks
    ////////////////////
    a_result0: assert property (@(negedge clk) chk_on |-> retire_o.result0 == exp_q.result0)
        else report_mismatch("result0", exp_q.result0, retire_o.result0);
    a_result1: assert property (@(negedge clk) chk_on |-> retire_o.result1 == exp_q.result1)
        else report_mismatch("result1", exp_q.result1, retire_o.result1);
    a_jump: assert property (@(negedge clk) chk_on |-> retire_o.jump == exp_q.jump)
        else report_mismatch("jump", 32'(exp_q.jump), 32'(retire_o.jump));
    a_we: assert property (@(negedge clk) chk_on |-> retire_o.we == exp_q.we)
        else report_mismatch("we", 32'(exp_q.we), 32'(retire_o.we));
    a_mem: assert property (@(negedge clk) chk_on |-> retire_o.mem_access == exp_q.mem_access)
        else report_mismatch("mem_access", 32'(exp_q.mem_access), 32'(retire_o.mem_access));
    a_write: assert property (@(negedge clk) chk_on |-> retire_o.write == exp_q.write)
        else report_mismatch("write", 32'(exp_q.write), 32'(retire_o.write));
    a_op: assert property (@(negedge clk) chk_on |-> retire_o.op == exp_q.op)
        else report_mismatch("op", 32'(exp_q.op), 32'(retire_o.op));
    a_tag: assert property (@(negedge clk) chk_on |-> retire_o.tag == exp_q.tag)
        else report_mismatch("tag", 32'(exp_q.tag), 32'(retire_o.tag));
    a_rd_en: assert property (@(negedge clk) chk_on |-> rd_req_o.en == exp_rd_en)
        else report_mismatch("rd_en", 32'(exp_rd_en), 32'(rd_req_o.en));
    a_rd_addr: assert property (@(negedge clk)
        chk_on && exp_rd_en |-> rd_req_o.addr == issue_i.op_a + issue_i.op_b)
        else report_mismatch("rd_addr", issue_i.op_a + issue_i.op_b, rd_req_o.addr);

    task automatic send(xu_e xu, instr_e op, logic [31:0] a, logic [31:0] b, logic [31:0] c);
        issue_t w;
        w.pc    = pc_cnt;
        w.op_a  = a;
        w.op_b  = b;
        w.op_c  = c;
        w.op    = op;
        w.xu    = xu;
        w.tag   = tag_cnt;
        @(posedge clk);
        issue_i    <= w;
        issue_name <= test_name;
        pc_cnt  = pc_cnt + 32'd4;
        tag_cnt = tag_cnt + 4'd1;
    endtask

    task automatic wait_retire(logic [3:0] tag);
        for (int n = 0; n < 8; n++) begin
            @(negedge clk);
            if (retire_o.tag == tag && retire_o.op == NOTOKEN) return;
        end
        timeouts++;
        $display("Timeout: final idle slot with tag %0d never retired", tag);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin
        instr_e r_op;
        xu_e    r_xu;
        rst_i      = 1'b1;
        issue_i    = '0;                                // Idle bypass slot
        chk_on     = 1'b0;
        mismatches = 0;
        timeouts   = 0;
        seed       = 32'h8463;
        pc_cnt     = 32'h0000_1000;
        tag_cnt    = '0;
        issue_name = "reset";
        for (int c = 0; c < RST_CYC; c++) @(posedge clk);
        rst_i <= 1'b0;

        test_name = "alu";                              // slt/sltu, sra of negatives
        for (int o = int'(OP_ADD); o <= int'(OP_SRA); o++)
            for (int i = 0; i < 6; i++)
                for (int j = 0; j < 6; j++)
                    send(unit_of(instr_e'(o)), instr_e'(o), CORNER[i], CORNER[j], 32'h0);
        test_name = "branch";                           // Odd offset tests jalr bit 0
        for (int o = int'(OP_BEQ); o <= int'(OP_JALR); o++)
            for (int i = 0; i < 6; i++)
                for (int j = 0; j < 6; j++)
                    send(XU_BRANCH, instr_e'(o), CORNER[i], CORNER[j], 32'h0000_0101);
        test_name = "memory";
        for (int o = int'(OP_LB); o <= int'(OP_SW); o++)
            for (int k = 0; k < 4; k++)
                send(XU_MEMORY, instr_e'(o), 32'h0000_2000, 32'(k), 32'hA1B2_C3D4);
        test_name = "dispatch";                         // Every op on every unit
        for (int x = 0; x <= int'(XU_MEMORY); x++)
            for (int o = 0; o <= int'(OP_SW); o++)
                send(xu_e'(x), instr_e'(o), CORNER[o % 6], CORNER[(o + x) % 6], 32'h13);
        test_name = "random";
        for (int n = 0; n < N_RAND; n++) begin
            r_op = instr_e'(5'(1 + $unsigned($random(seed)) % 26));
            r_xu = ($random(seed) % 8 == 0) ? XU_BYPASS : unit_of(r_op);
            send(r_xu, r_op, pick_operand(), pick_operand(), pick_operand());
        end
        test_name = "drain";
        send(XU_BYPASS, NOTOKEN, 32'h0, 32'h0, 32'h0);
        wait_retire(tag_cnt - 4'd1);
        @(posedge clk);                                 // Last negedge checks complete
        $display("Checks done: mismatches=%0d timeouts=%0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        for (int c = 0; c < MAX_CYC; c++) @(posedge clk);
        $display("Timeout: stimulus did not finish within %0d cycles", MAX_CYC);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
